// ==== Makefile ====
TOP := drf_system_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

obj_dir/V$(TOP): build.f $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
verilog/drf_pkg.sv
verilog/alu.sv
verilog/register_bank.sv
verilog/program_counter.sv
verilog/control_unit.sv
verilog/code_memory.sv
verilog/data_memory_manager.sv
verilog/drf_system.sv
sim/drf_system_props.sv
sim/drf_system_tb.sv

// ==== sim/drf_system_props.sv ====
// Bound assertions on port output values, halt behavior and reset state
`timescale 1ns/1ps
`default_nettype none

module drf_system_props import drf_pkg::*; (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire logic [port_w-1:0] port_input,
  input wire logic [port_w-1:0] port_output,
  input wire logic              halted,
  input wire logic              mem_write,
  input wire logic [data_w-1:0] ry_data
);

  // Failure count, read by the testbench summary
  int unsigned       fail_cnt = 0;
  logic              port_store;
  logic [2:0]        store_cnt;
  logic [port_w-1:0] expected;
  logic [port_w-1:0] store_expected;

  // The test program reaches the port only through pointer 0xFF
  assign port_store = mem_write && (ry_data == port_addr[data_w-1:0]);

  // Value the port must show one clock after the store
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      store_cnt      <= '0;
      store_expected <= '0;
    end else if (port_store) begin
      store_cnt      <= store_cnt + 1'b1;
      store_expected <= expected;
    end
  end

  // Output sequence of the test program
  always_comb begin
    case (store_cnt)
      3'd0:    expected = port_input + 4'd3;
      3'd1:    expected = 4'hA;
      3'd2:    expected = 4'h5;
      default: expected = 4'hC ^ 4'h6;
    endcase
  end

  a_reset_state: assert property (@(posedge clk)
    !rst_n |=> (port_output == '0) && !halted)
    else begin
      fail_cnt++;
      $error("ERROR reset_state: expected port 0 halted 0, actual port %0h halted %0b",
             port_output, halted);
    end

  a_idle_before_store: assert property (@(posedge clk) disable iff (!rst_n)
    (store_cnt == 3'd0) |-> (port_output == '0) && !halted)
    else begin
      fail_cnt++;
      $error("ERROR idle_before_store: expected port 0 halted 0, actual port %0h halted %0b",
             port_output, halted);
    end

  a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
    port_store |=> (port_output == store_expected))
    else begin
      fail_cnt++;
      $error("ERROR store_value %0d: expected %0h, actual %0h",
             store_cnt, store_expected, port_output);
    end

  a_store_count: assert property (@(posedge clk) disable iff (!rst_n)
    port_store |-> (store_cnt < 3'd4))
    else begin
      fail_cnt++;
      $error("more port stores than the program holds");
    end

  a_halt_after_program: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> (store_cnt == 3'd4))
    else begin
      fail_cnt++;
      $error("halted before all four port stores");
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && $stable(port_output))
    else begin
      fail_cnt++;
      $error("halted dropped or port output moved while halted");
    end

endmodule

`default_nettype wire

// ==== sim/drf_system_tb.sv ====
// Testbench for drf_system with clock, reset, port stimulus, timeouts and summary
`timescale 1ns/1ps
`default_nettype none

module drf_system_tb import drf_pkg::*; ();

  logic                   clk;
  logic                   rst_n;
  logic      [port_w-1:0] port_input;
  wire logic [port_w-1:0] port_output;
  wire logic              halted;
  integer                 seed;
  int                     timeout_cnt;
  int                     fail_total;

  drf_system i_drf_system (
    .clk         (clk),
    .rst_n       (rst_n),
    .port_input  (port_input),
    .port_output (port_output),
    .halted      (halted)
  );

  bind drf_system drf_system_props i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .port_input  (port_input),
    .port_output (port_output),
    .halted      (halted),
    .mem_write   (mem_write),
    .ry_data     (ry_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // New input value that keeps every port store a visible change
  task automatic pick_input();
    logic [port_w-1:0] value;
    value = 4'd7;
    // 7 would repeat 0xA, 13 would repeat the reset value
    while (value == 4'd7 || value == 4'd13) begin
      value = port_w'($random(seed));
    end
    port_input = value;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    pick_input();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_port_change(input string step);
    logic [port_w-1:0] prev;
    int                cycles;
    prev   = port_output;
    cycles = 0;
    while (port_output == prev && cycles < 300) begin
      @(negedge clk);
      cycles++;
    end
    if (port_output == prev) begin
      $display("Timeout: port output did not change in %s", step);
      timeout_cnt++;
    end
  endtask

  task automatic wait_halt(input string run);
    int cycles;
    cycles = 0;
    while (!halted && cycles < 300) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: %s never reached the halt instruction", run);
      timeout_cnt++;
    end
  endtask

  // Four port stores, then halt, then a quiet stretch with the port held
  task automatic run_program(input string run);
    wait_port_change({run, ", input plus three"});
    wait_port_change({run, ", countdown loop"});
    wait_port_change({run, ", banked load"});
    wait_port_change({run, ", xor result"});
    wait_halt(run);
    repeat (20) @(negedge clk);
  endtask

  initial begin
    seed        = 73;
    timeout_cnt = 0;
    rst_n       = 1'b0;
    port_input  = '0;

    apply_reset();
    run_program("first run");

    // Second run cut short by a reset after its first output
    apply_reset();
    wait_port_change("interrupted run, input plus three");
    apply_reset();
    run_program("run after mid-run reset");

    fail_total = timeout_cnt + int'(i_drf_system.i_props.fail_cnt);
    $display("Summary: %0d timeouts, %0d assertion failures",
             timeout_cnt, i_drf_system.i_props.fail_cnt);
    if (fail_total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/program.hex ====
// One 16-bit instruction word per line in address order from 0
// Fields are opcode 15..11, rx 10..8, ry 7..5, imm 7..0, target 8..0, bank 10..9
0000 // 00 nop
2E00 // 01 bank 3 for the port
0FFF // 02 ldi r7, 0xFF
19E0 // 03 ld r1, [r7] reads port_input
0A03 // 04 ldi r2, 3
1140 // 05 add r1, r2
21E0 // 06 st r1, [r7] first output
0B05 // 07 ldi r3, 5
0C01 // 08 ldi r4, 1
1381 // 09 sub r3, r4 loop head
380C // 0A jz 0x0C
3009 // 0B jmp 0x09
0D0A // 0C ldi r5, 0x0A
25E0 // 0D st r5, [r7] second output
2C00 // 0E bank 2
0E10 // 0F ldi r6, 0x10
0905 // 10 ldi r1, 0x05
21C0 // 11 st r1, [r6]
2800 // 12 bank 0
0909 // 13 ldi r1, 0x09
21C0 // 14 st r1, [r6]
2C00 // 15 bank 2
1AC0 // 16 ld r2, [r6]
2E00 // 17 bank 3
22E0 // 18 st r2, [r7] third output
0B0C // 19 ldi r3, 0x0C
0C06 // 1A ldi r4, 0x06
1384 // 1B xor r3, r4
23E0 // 1C st r3, [r7] fourth output
F800 // 1D halt

// ==== verilog/alu.sv ====
// Eight-operation ALU with combinational result and registered flags
`timescale 1ns/1ps
`default_nettype none

module alu import drf_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [data_w-1:0] a,
  input  wire logic [data_w-1:0] b,
  input  wire alu_op_t           op,
  input  wire logic              flags_write,
  output logic      [data_w-1:0] result,
  output logic      [3:0]        flags
);

  // Extra top bit carries the carry or the shifted-out bit
  logic [data_w:0] wide;
  logic            ovf;

  always_comb begin
    wide = '0;
    ovf  = 1'b0;
    case (op)
      alu_add: begin
        wide = {1'b0, a} + {1'b0, b};
        ovf  = (a[data_w-1] == b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
      end
      alu_sub: begin
        // Top bit is the borrow
        wide = {1'b0, a} - {1'b0, b};
        ovf  = (a[data_w-1] != b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
      end
      alu_and: wide = {1'b0, a & b};
      alu_or:  wide = {1'b0, a | b};
      alu_xor: wide = {1'b0, a ^ b};
      alu_not: wide = {1'b0, ~a};
      alu_shl: wide = {a, 1'b0};
      alu_shr: wide = {a[0], 1'b0, a[data_w-1:1]};
      default: wide = '0;
    endcase
  end

  assign result = wide[data_w-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flags_write) begin
      flags[flag_zero]     <= (result == '0);
      flags[flag_carry]    <= wide[data_w];
      flags[flag_negative] <= result[data_w-1];
      flags[flag_overflow] <= ovf;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/code_memory.sv ====
// Instruction ROM with registered read, loaded from a hex image
`timescale 1ns/1ps
`default_nettype none

module code_memory import drf_pkg::*; (
  input  wire logic               clk,
  input  wire logic [pc_w-1:0]    addr,
  output logic      [instr_w-1:0] instr
);

  logic [instr_w-1:0] rom [code_depth];

  initial begin
    $readmemh(code_init_file, rom);
  end

  always_ff @(posedge clk) begin
    instr <= rom[addr];
  end

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
// Instruction register, fetch/exec/mem/halt FSM and opcode decode
`timescale 1ns/1ps
`default_nettype none

module control_unit import drf_pkg::*; (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic [instr_w-1:0] instr,
  input  wire logic               zero_flag,
  output logic      [instr_w-1:0] ir,
  output logic                    pc_inc,
  output logic                    pc_load,
  output logic                    reg_write,
  output logic      [1:0]         result_sel,
  output alu_op_t                 alu_op,
  output logic                    flags_write,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    bank_write,
  output logic                    indirect_en,
  output logic                    halted
);

  cu_state_t state;
  cu_state_t state_next;
  opcode_t   opcode;
  logic      in_exec;
  logic      jump_taken;

  assign opcode  = opcode_t'(ir[15:11]);
  assign alu_op  = alu_op_t'(ir[2:0]);
  assign in_exec = (state == st_exec);

  always_comb begin
    state_next = state;
    case (state)
      st_fetch: state_next = st_exec;
      st_exec: begin
        if (opcode == op_ld) begin
          state_next = st_mem;
        end else if (opcode == op_halt) begin
          state_next = st_halt;
        end else begin
          state_next = st_fetch;
        end
      end
      st_mem:  state_next = st_fetch;
      default: state_next = st_halt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_fetch;
      ir    <= '0;
    end else begin
      state <= state_next;
      // ROM word is valid during fetch
      if (state == st_fetch) begin
        ir <= instr;
      end
    end
  end

  // Flag was registered by the last ALU instruction
  assign jump_taken = (opcode == op_jmp) || (opcode == op_jz && zero_flag);

  // Unknown opcodes fall through as nop
  assign pc_load = in_exec && jump_taken;
  assign pc_inc  = in_exec && !jump_taken && (opcode != op_halt);

  assign reg_write = (in_exec && (opcode == op_ldi || opcode == op_alu)) ||
                     (state == st_mem);

  always_comb begin
    if (state == st_mem) begin
      result_sel = res_mem;
    end else if (opcode == op_ldi) begin
      result_sel = res_imm;
    end else begin
      result_sel = res_alu;
    end
  end

  assign flags_write = in_exec && (opcode == op_alu);
  assign mem_read    = in_exec && (opcode == op_ld);
  assign mem_write   = in_exec && (opcode == op_st);
  assign bank_write  = in_exec && (opcode == op_bank);

  // ry holds the data pointer for loads and stores
  assign indirect_en = (in_exec && (opcode == op_ld || opcode == op_st)) ||
                       (state == st_mem);

  assign halted = (state == st_halt);

endmodule

`default_nettype wire

// ==== verilog/data_memory_manager.sv ====
// Banked 1 KiB data RAM, bank select register and 4-bit I/O port
`timescale 1ns/1ps
`default_nettype none

module data_memory_manager import drf_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              read_en,
  input  wire logic              write_en,
  input  wire logic              bank_write,
  input  wire logic [bank_w-1:0] bank_in,
  input  wire logic [data_w-1:0] addr,
  input  wire logic [data_w-1:0] write_data,
  input  wire logic [port_w-1:0] port_input,
  output logic      [data_w-1:0] read_data,
  output logic      [port_w-1:0] port_output
);

  logic [data_w-1:0]  ram [dmem_depth];
  logic [bank_w-1:0]  bank;
  logic [dmem_aw-1:0] full_addr;
  logic               at_port;

  assign full_addr = {bank, addr};
  assign at_port   = (full_addr == port_addr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank        <= '0;
      port_output <= '0;
    end else begin
      if (bank_write) begin
        bank <= bank_in;
      end
      if (write_en && at_port) begin
        port_output <= write_data[port_w-1:0];
      end
    end
  end

  // Port address shadows the last RAM byte
  always_ff @(posedge clk) begin
    if (write_en && !at_port) begin
      ram[full_addr] <= write_data;
    end
    if (read_en) begin
      read_data <= at_port ? {{(data_w-port_w){1'b0}}, port_input} : ram[full_addr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/drf_pkg.sv ====
// Shared widths, flag indices, port address, opcode, ALU and FSM state types
`default_nettype none

package drf_pkg;

  localparam int data_w    = 8;
  localparam int instr_w   = 16;
  localparam int pc_w      = 9;
  localparam int reg_sel_w = 3;
  localparam int bank_w    = 2;
  localparam int port_w    = 4;

  // Derived memory sizes
  localparam int code_depth = 2 ** pc_w;
  localparam int dmem_aw    = bank_w + data_w;
  localparam int dmem_depth = 2 ** dmem_aw;

  // Bit positions in the ALU flag word
  localparam int flag_zero     = 0;
  localparam int flag_carry    = 1;
  localparam int flag_negative = 2;
  localparam int flag_overflow = 3;

  // Top data address is the I/O port
  localparam logic [dmem_aw-1:0] port_addr = 10'h3FF;

  // Register write source select
  localparam logic [1:0] res_alu = 2'd0;
  localparam logic [1:0] res_imm = 2'd1;
  localparam logic [1:0] res_mem = 2'd2;

  localparam string code_init_file = "sim/program.hex";

  typedef enum logic [4:0] {
    op_nop  = 5'h00,
    op_ldi  = 5'h01,
    op_alu  = 5'h02,
    op_ld   = 5'h03,
    op_st   = 5'h04,
    op_bank = 5'h05,
    op_jmp  = 5'h06,
    op_jz   = 5'h07,
    op_halt = 5'h1F
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_not = 3'd5,
    alu_shl = 3'd6,
    alu_shr = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    st_fetch = 2'd0,
    st_exec  = 2'd1,
    st_mem   = 2'd2,
    st_halt  = 2'd3
  } cu_state_t;

endpackage

`default_nettype wire

// ==== verilog/drf_system.sv ====
// Processor top level with block wiring, ROM address and result mux
`timescale 1ns/1ps
`default_nettype none

module drf_system import drf_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [port_w-1:0] port_input,
  output logic      [port_w-1:0] port_output,
  output logic                   halted
);

  logic [instr_w-1:0] instr;
  logic [instr_w-1:0] ir;
  logic [pc_w-1:0]    pc;
  logic [pc_w-1:0]    code_addr;
  logic               pc_inc;
  logic               pc_load;
  logic               reg_write;
  logic [1:0]         result_sel;
  alu_op_t            alu_op;
  logic               flags_write;
  logic               mem_read;
  logic               mem_write;
  logic               bank_write;
  logic               indirect_en;
  logic [data_w-1:0]  rx_data;
  logic [data_w-1:0]  ry_data;
  logic [data_w-1:0]  alu_result;
  logic [3:0]         alu_flags;
  logic [data_w-1:0]  mem_data;
  logic [data_w-1:0]  reg_wdata;

  // ROM sees the next PC so the word is ready in fetch
  assign code_addr = pc_load ? ir[8:0] : (pc_inc ? pc + 1'b1 : pc);

  always_comb begin
    case (result_sel)
      res_imm: reg_wdata = ir[7:0];
      res_mem: reg_wdata = mem_data;
      default: reg_wdata = alu_result;
    endcase
  end

  code_memory i_code_memory (
    .clk   (clk),
    .addr  (code_addr),
    .instr (instr)
  );

  program_counter i_program_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .inc    (pc_inc),
    .load   (pc_load),
    .target (ir[8:0]),
    .pc     (pc)
  );

  control_unit i_control_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .zero_flag   (alu_flags[flag_zero]),
    .ir          (ir),
    .pc_inc      (pc_inc),
    .pc_load     (pc_load),
    .reg_write   (reg_write),
    .result_sel  (result_sel),
    .alu_op      (alu_op),
    .flags_write (flags_write),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .bank_write  (bank_write),
    .indirect_en (indirect_en),
    .halted      (halted)
  );

  register_bank i_register_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_en    (reg_write),
    .rx_sel      (ir[10:8]),
    .ry_sel      (ir[7:5]),
    .indirect_en (indirect_en),
    .write_data  (reg_wdata),
    .rx_data     (rx_data),
    .ry_data     (ry_data)
  );

  alu i_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .a           (rx_data),
    .b           (ry_data),
    .op          (alu_op),
    .flags_write (flags_write),
    .result      (alu_result),
    .flags       (alu_flags)
  );

  // Low address byte comes from the pointer register
  data_memory_manager i_data_memory_manager (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_en     (mem_read),
    .write_en    (mem_write),
    .bank_write  (bank_write),
    .bank_in     (ir[10:9]),
    .addr        (ry_data),
    .write_data  (rx_data),
    .port_input  (port_input),
    .read_data   (mem_data),
    .port_output (port_output)
  );

endmodule

`default_nettype wire

// ==== verilog/program_counter.sv ====
// 9-bit program counter with increment and jump load
`timescale 1ns/1ps
`default_nettype none

module program_counter import drf_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            inc,
  input  wire logic            load,
  input  wire logic [pc_w-1:0] target,
  output logic      [pc_w-1:0] pc
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (load) begin
      // Jump wins over the step
      pc <= target;
    end else if (inc) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/register_bank.sv ====
// Eight 8-bit registers, two read ports, rx write port, pointer read on ry
`timescale 1ns/1ps
`default_nettype none

module register_bank import drf_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 write_en,
  input  wire logic [reg_sel_w-1:0] rx_sel,
  input  wire logic [reg_sel_w-1:0] ry_sel,
  input  wire logic                 indirect_en,
  input  wire logic [data_w-1:0]    write_data,
  output logic      [data_w-1:0]    rx_data,
  output logic      [data_w-1:0]    ry_data
);

  logic [data_w-1:0] regs [2**reg_sel_w];
  logic              ptr_bypass;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_sel_w; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[rx_sel] <= write_data;
    end
  end

  assign rx_data = regs[rx_sel];

  // As a memory pointer, ry sees a same-cycle write to it so the
  // address always follows the newest pointer value
  assign ptr_bypass = indirect_en && write_en && (ry_sel == rx_sel);

  assign ry_data = ptr_bypass ? write_data : regs[ry_sel];

endmodule

`default_nettype wire
